// ==== Bender.yml ====
package:
  name: risc14

sources:
  - source/riscPkg.sv
  - source/programRom.sv
  - source/dataRam.sv
  - source/regFile.sv
  - source/aluUnit.sv
  - source/controlUnit.sv
  - source/riscCore.sv
  - target: test
    files:
      - verif/riscTb.sv

// ==== program.hex ====
// one 14-bit word per line from address 0: opcode[13:8] Ri[7:4] Rj[3:0], or an address word
0104 // LD R4, switches
3FC0
0204 // ST R4 to RAM word 16
0010
0105 // LD R5 back from RAM word 16
0010
0365 // CPY R6, R5
2263 // ADDC R6, 3
2C62 // SHLL R6, 2
2B64 // XOR R6, R4
2D61 // SHRL R6, 1
2350 // SUBC R5, 0 sets z when the switches are zero
100E // JZ0 over the NOT
000F
2860 // NOT R6
0206 // ST R6 to the LEDs
3FC1
1000 // JU back to the start
0000

// ==== sim.f ====
source/riscPkg.sv
source/programRom.sv
source/dataRam.sv
source/regFile.sv
source/aluUnit.sv
source/controlUnit.sv
source/riscCore.sv
verif/riscTb.sv

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit
(
	input riscPkg::aluOp_t aluOp,
	input riscPkg::word_t operandA,
	input riscPkg::word_t operandB,
	input logic carryIn,
	output riscPkg::word_t aluResult,
	output riscPkg::flags_t aluFlags
);

	riscPkg::word_t addend;
	logic [riscPkg::wordW:0] sum;	// one extra bit for carry out
	riscPkg::word_t result;
	logic carry;
	logic ovf;

	// --------------------
	// adder, shared by add and sub
	// --------------------
	assign addend = (aluOp == riscPkg::opSub) ? ~operandB : operandB;
	assign sum = {1'b0, operandA} + {1'b0, addend} + {{riscPkg::wordW{1'b0}}, carryIn};

	always_comb
	begin
		carry = 1'b0;	// logic ops leave c and v clear
		ovf = 1'b0;
		case (aluOp)
			riscPkg::opAdd, riscPkg::opSub:
			begin
				result = sum[riscPkg::wordW-1:0];
				carry = sum[riscPkg::wordW];
				// same sign in, different sign out
				ovf = (operandA[riscPkg::wordW-1] == addend[riscPkg::wordW-1]) &&
					(result[riscPkg::wordW-1] != operandA[riscPkg::wordW-1]);
			end
			riscPkg::opXor:
				result = operandA ^ operandB;
			riscPkg::opNot:
				result = ~operandA;
			riscPkg::opShl:
			begin
				if (operandB < riscPkg::wordW)
					result = operandA << operandB;
				else
					result = '0;	// count of 14 or more
			end
			riscPkg::opShr:
			begin
				if (operandB < riscPkg::wordW)
					result = operandA >> operandB;
				else
					result = '0;
			end
			riscPkg::opPass:
				result = operandB;
			default:
				result = operandA;
		endcase
	end

	assign aluResult = result;

	// --------------------
	// status flags
	// --------------------
	assign aluFlags[riscPkg::flagC] = carry;
	assign aluFlags[riscPkg::flagN] = result[riscPkg::wordW-1];
	assign aluFlags[riscPkg::flagV] = ovf;
	assign aluFlags[riscPkg::flagZ] = (result == '0);

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
(
	input logic Clock_pin,
	input logic rstN,
	input logic [4:0] SW_pin,
	input riscPkg::word_t instrWord,
	input riscPkg::word_t rdDataA,
	input riscPkg::word_t rdDataB,
	input riscPkg::word_t aluResult,
	input riscPkg::flags_t aluFlags,
	input riscPkg::word_t memRdData,
	output riscPkg::word_t pc,
	output riscPkg::regIdx_t rdIdxA,
	output riscPkg::regIdx_t rdIdxB,
	output logic wrEn,
	output riscPkg::regIdx_t wrIdx,
	output riscPkg::word_t wrData,
	output riscPkg::aluOp_t aluOp,
	output riscPkg::word_t operandA,
	output riscPkg::word_t operandB,
	output logic carryIn,
	output riscPkg::word_t memAddr,
	output riscPkg::word_t memWrData,
	output logic memWrEn,
	output logic [7:0] Display_pin
);

	riscPkg::machCycle_t mc;
	riscPkg::word_t ir;	// instruction register
	riscPkg::word_t addrWord;	// second word of LD, ST, JMP
	riscPkg::word_t indexVal;
	riscPkg::word_t effAddr;
	riscPkg::word_t effNext;
	riscPkg::word_t resultReg;
	riscPkg::word_t pcInc;
	riscPkg::word_t opBSel;
	riscPkg::word_t loadData;
	riscPkg::flags_t sr;	// status register
	riscPkg::flags_t flagsTmp;
	riscPkg::opcode_t opcode;
	riscPkg::regIdx_t ri;
	riscPkg::regIdx_t rj;
	logic needsAddr;
	logic isAlu;
	logic ioHit;
	logic jmpTaken;

	// --------------------
	// decode
	// --------------------
	assign opcode = riscPkg::opcode_t'(ir[13:8]);
	assign ri = ir[7:4];	// dest for ALU and CPY, index for LD/ST/JMP
	assign rj = ir[3:0];	// source, constant, count or jump condition
	assign pcInc = pc + 14'd1;

	assign needsAddr = (opcode == riscPkg::LD_IC) || (opcode == riscPkg::ST_IC) ||
		(opcode == riscPkg::JMP_IC);
	assign isAlu = (opcode == riscPkg::ADDC_IC) || (opcode == riscPkg::SUBC_IC) ||
		(opcode == riscPkg::XOR_IC) || (opcode == riscPkg::NOT_IC) ||
		(opcode == riscPkg::SHLL_IC) || (opcode == riscPkg::SHRL_IC);

	always_comb
	begin
		case (opcode)
			riscPkg::ADDC_IC: aluOp = riscPkg::opAdd;
			riscPkg::SUBC_IC: aluOp = riscPkg::opSub;
			riscPkg::XOR_IC: aluOp = riscPkg::opXor;
			riscPkg::NOT_IC: aluOp = riscPkg::opNot;
			riscPkg::SHLL_IC: aluOp = riscPkg::opShl;
			riscPkg::SHRL_IC: aluOp = riscPkg::opShr;
			default: aluOp = riscPkg::opPass;	// CPY and everything else
		endcase
	end

	assign carryIn = (opcode == riscPkg::SUBC_IC);	// two's complement +1

	// constant and shift count come from the Rj field
	assign opBSel = (opcode == riscPkg::ADDC_IC || opcode == riscPkg::SUBC_IC ||
		opcode == riscPkg::SHLL_IC || opcode == riscPkg::SHRL_IC) ?
		{10'b0, rj} : rdDataB;

	assign rdIdxA = ri;
	assign rdIdxB = rj;

	// --------------------
	// address and IO
	// --------------------
	assign effNext = addrWord + indexVal;
	assign ioHit = (effAddr[13:6] == riscPkg::ioPage);
	assign memAddr = effAddr;
	assign memWrData = rdDataB;	// ST writes R[Rj]

	always_comb
	begin
		if (ioHit)
			loadData = (effAddr == riscPkg::switchAddr) ?
				{{(riscPkg::wordW-5){1'b0}}, SW_pin} : '0;
		else
			loadData = memRdData;
	end

	// jump condition against the status register
	always_comb
	begin
		case (riscPkg::jmpCond_t'(rj))
			riscPkg::JU: jmpTaken = 1'b1;
			riscPkg::JC1, riscPkg::JN1, riscPkg::JV1, riscPkg::JZ1:
				jmpTaken = ((sr & rj) == rj);
			riscPkg::JC0, riscPkg::JN0, riscPkg::JV0, riscPkg::JZ0:
				jmpTaken = ((sr | rj) == rj);
			default: jmpTaken = 1'b0;
		endcase
	end

	// --------------------
	// write back in MC3
	// --------------------
	assign wrEn = (mc == riscPkg::MC3) &&
		(isAlu || opcode == riscPkg::CPY_IC || opcode == riscPkg::LD_IC);
	assign wrIdx = (opcode == riscPkg::LD_IC) ? rj : ri;
	assign wrData = (opcode == riscPkg::LD_IC) ? loadData : resultReg;

	// sequencer and architectural state
	always_ff @(posedge Clock_pin)
	begin
		if (!rstN)
		begin
			mc <= riscPkg::MC0;
			pc <= '0;
			ir <= '0;
			sr <= '0;
			memWrEn <= 1'b0;
			Display_pin <= '0;
		end
		else
		begin
			case (mc)
				riscPkg::MC0:
				begin
					ir <= instrWord;	// fetch
					pc <= pcInc;
					mc <= riscPkg::MC1;
				end
				riscPkg::MC1:
				begin
					if (needsAddr)
						pc <= pcInc;	// skip over the address word
					mc <= riscPkg::MC2;
				end
				riscPkg::MC2:
				begin
					// IO stores never reach the RAM
					memWrEn <= (opcode == riscPkg::ST_IC) && (effNext[13:6] != riscPkg::ioPage);
					mc <= riscPkg::MC3;
				end
				default:
				begin
					memWrEn <= 1'b0;
					if (opcode == riscPkg::JMP_IC && jmpTaken)
						pc <= effAddr;
					if (isAlu)
						sr <= flagsTmp;
					if (opcode == riscPkg::ST_IC && effAddr == riscPkg::displayAddr)
						Display_pin <= rdDataB[7:0];	// LEDs
					mc <= riscPkg::MC0;
				end
			endcase
		end
	end

	// datapath latches
	always_ff @(posedge Clock_pin)
	begin
		if (mc == riscPkg::MC1)
		begin
			addrWord <= instrWord;
			operandA <= rdDataA;
			operandB <= opBSel;
			case (ri)
				4'd0: indexVal <= '0;
				4'd1: indexVal <= pcInc;	// pc after the address word
				default: indexVal <= rdDataA;
			endcase
		end
		if (mc == riscPkg::MC2)
		begin
			effAddr <= effNext;
			resultReg <= aluResult;
			flagsTmp <= aluFlags;
		end
	end

	aMemWrInMc3: assert property (@(posedge Clock_pin) disable iff (!rstN)
		memWrEn |-> mc == riscPkg::MC3);

	aMemWrNotIo: assert property (@(posedge Clock_pin) disable iff (!rstN)
		memWrEn |-> memAddr[13:6] != riscPkg::ioPage);

endmodule

// ==== source/dataRam.sv ====
`timescale 1ns/1ps

module dataRam
(
	input logic Clock_pin,
	input riscPkg::word_t memAddr,
	input riscPkg::word_t memWrData,
	input logic memWrEn,
	output riscPkg::word_t memRdData
);

	localparam int ramWords = 2 ** riscPkg::memAddrW;

	riscPkg::word_t ram [ramWords];
	logic [riscPkg::memAddrW-1:0] ramAddr;

	assign ramAddr = memAddr[riscPkg::memAddrW-1:0];	// upper bits not decoded

	// --------------------
	// falling edge port
	// --------------------
	always_ff @(negedge Clock_pin)
	begin
		if (memWrEn)
		begin
			ram[ramAddr] <= memWrData;
		end
		memRdData <= ram[ramAddr];	// old data on a write cycle
	end

endmodule

// ==== source/programRom.sv ====
`timescale 1ns/1ps

module programRom
(
	input logic Clock_pin,
	input riscPkg::word_t pc,
	output riscPkg::word_t instrWord
);

	localparam int romWords = 2 ** riscPkg::memAddrW;

	riscPkg::word_t rom [romWords];	// one instruction per word

	initial
	begin
		$readmemh("program.hex", rom);
	end

	// read on the falling edge, word is ready by the next rising edge
	always_ff @(negedge Clock_pin)
	begin
		instrWord <= rom[pc[riscPkg::memAddrW-1:0]];
	end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile
(
	input logic Clock_pin,
	input logic rstN,
	input riscPkg::regIdx_t rdIdxA,
	input riscPkg::regIdx_t rdIdxB,
	input logic wrEn,
	input riscPkg::regIdx_t wrIdx,
	input riscPkg::word_t wrData,
	output riscPkg::word_t rdDataA,
	output riscPkg::word_t rdDataB
);

	riscPkg::word_t regs [riscPkg::numRegs];

	always_ff @(posedge Clock_pin)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < riscPkg::numRegs; i++)
				regs[i] <= '0;
		end
		else if (wrEn)
		begin
			regs[wrIdx] <= wrData;
		end
	end

	assign rdDataA = regs[rdIdxA];	// combinational read ports
	assign rdDataB = regs[rdIdxB];

	// write-back data comes from the ALU result latch or a memory load
	aWrDataKnown: assert property (@(posedge Clock_pin) disable iff (!rstN)
		wrEn |-> !$isunknown(wrData));

endmodule

// ==== source/riscCore.sv ====
`timescale 1ns/1ps

module riscCore
(
	input logic Clock_pin,
	input logic rstN,
	input logic [4:0] SW_pin,
	output logic [7:0] Display_pin
);

	riscPkg::word_t pc;
	riscPkg::word_t instrWord;
	riscPkg::regIdx_t rdIdxA;
	riscPkg::regIdx_t rdIdxB;
	riscPkg::word_t rdDataA;
	riscPkg::word_t rdDataB;
	logic wrEn;
	riscPkg::regIdx_t wrIdx;
	riscPkg::word_t wrData;
	riscPkg::aluOp_t aluOp;
	riscPkg::word_t operandA;
	riscPkg::word_t operandB;
	logic carryIn;
	riscPkg::word_t aluResult;
	riscPkg::flags_t aluFlags;
	riscPkg::word_t memAddr;
	riscPkg::word_t memWrData;
	logic memWrEn;
	riscPkg::word_t memRdData;

	// --------------------
	// sequencer and datapath
	// --------------------
	controlUnit uCtrl (.*);

	aluUnit uAlu (.*);

	regFile uRegs (.*);

	// --------------------
	// memories
	// --------------------
	programRom uRom (.*);

	dataRam uRam (.*);

endmodule

// ==== source/riscPkg.sv ====
package riscPkg;

	// --------------------
	// widths
	// --------------------
	localparam int wordW = 14;
	localparam int memAddrW = 10;	// address bits decoded by each memory
	localparam int numRegs = 16;

	typedef logic [wordW-1:0] word_t;	// data, address and instruction word
	typedef logic [3:0] regIdx_t;	// register index, shift count or jump condition
	typedef logic [3:0] flags_t;	// c n v z, high to low

	// bit positions inside flags_t
	localparam int flagC = 3;
	localparam int flagN = 2;
	localparam int flagV = 1;
	localparam int flagZ = 0;

	// --------------------
	// opcodes
	// --------------------
	typedef enum logic [5:0]
	{
		NOP_IC = 6'h00,
		LD_IC = 6'h01,
		ST_IC = 6'h02,
		CPY_IC = 6'h03,
		JMP_IC = 6'h10,
		ADDC_IC = 6'h22,
		SUBC_IC = 6'h23,
		NOT_IC = 6'h28,
		XOR_IC = 6'h2B,
		SHLL_IC = 6'h2C,
		SHRL_IC = 6'h2D
	} opcode_t;

	// set forms test the single 1 bit, clear forms the single 0 bit
	typedef enum logic [3:0]
	{
		JU = 4'b0000,
		JC1 = 4'b1000,
		JN1 = 4'b0100,
		JV1 = 4'b0010,
		JZ1 = 4'b0001,
		JC0 = 4'b0111,
		JN0 = 4'b1011,
		JV0 = 4'b1101,
		JZ0 = 4'b1110
	} jmpCond_t;

	typedef enum logic [2:0]
	{
		opAdd,
		opSub,
		opXor,
		opNot,
		opShl,
		opShr,
		opPass
	} aluOp_t;

	typedef enum logic [1:0] {MC0, MC1, MC2, MC3} machCycle_t;

	// --------------------
	// IO region, top 64 words
	// --------------------
	localparam logic [7:0] ioPage = 8'hFF;
	localparam word_t switchAddr = 14'h3FC0;
	localparam word_t displayAddr = 14'h3FC1;

endpackage

// ==== verif/riscTb.sv ====
`timescale 1ns/1ps

module riscTb;

	localparam int numEntries = 8;
	localparam int updateTimeout = 400;	// cycles
	localparam int holdCycles = 120;	// a bit over two program passes

	logic Clock_pin;
	logic rstN;
	logic [4:0] SW_pin;
	logic [7:0] Display_pin;

	logic [4:0] swTable [numEntries];
	logic [7:0] expTable [numEntries];
	bit fixedSlot [numEntries];
	integer seed;

	riscCore dut
	(
		.Clock_pin(Clock_pin),
		.rstN(rstN),
		.SW_pin(SW_pin),
		.Display_pin(Display_pin)
	);

	initial
	begin
		Clock_pin = 1'b0;
	end

	always
	begin
		#50 Clock_pin = ~Clock_pin;	// 100 ns period
	end

	// --------------------
	// reference model
	// --------------------
	function automatic logic [7:0] modelDisplay(input logic [4:0] sw);
		riscPkg::word_t a;
		riscPkg::word_t r;
		a = {9'b0, sw};
		r = (a + 14'd3) << 2;
		r = r ^ a;
		r = r >> 1;
		if (a == '0)
			r = ~r;	// JZ0 falls through to NOT
		return r[7:0];
	endfunction

	task automatic setEntry(input int idx, input logic [4:0] sw);
		swTable[idx] = sw;
		expTable[idx] = modelDisplay(sw);
		fixedSlot[idx] = 1'b1;
	endtask

	// random slots are redrawn until they differ from both neighbours
	task automatic buildTable();
		int tries;
		logic clash;
		for (int i = 0; i < numEntries; i++)
			fixedSlot[i] = 1'b0;
		setEntry(0, 5'd0);
		setEntry(2, 5'd1);
		setEntry(4, 5'd31);
		setEntry(7, 5'd0);
		for (int i = 0; i < numEntries; i++)
		begin
			if (!fixedSlot[i])
			begin
				tries = 0;
				do
				begin
					swTable[i] = $random(seed);	// low 5 bits kept
					expTable[i] = modelDisplay(swTable[i]);
					clash = (i > 0 && expTable[i] == expTable[i-1]) ||
						(i < numEntries - 1 && fixedSlot[i+1] && expTable[i] == expTable[i+1]);
					tries++;
				end
				while (clash && tries < 64);
			end
		end
	endtask

	// --------------------
	// checks
	// --------------------
	task automatic checkDisplay(input logic [7:0] actual, input logic [7:0] expected);
		if (actual !== expected)
		begin
			$display("Fail Display_pin expected 0x%h actual 0x%h", expected, actual);
			$display("TB FAILED");
			$fatal(1, "display mismatch");
		end
	endtask

	task automatic waitForDisplay(input logic [7:0] expected);
		int cycles;
		cycles = 0;
		while (Display_pin !== expected && cycles < updateTimeout)
		begin
			@(negedge Clock_pin);	// display moves on the rising edge
			cycles++;
		end
		if (Display_pin !== expected)
		begin
			$display("Display_pin never updated to 0x%h within %0d cycles",
				expected, updateTimeout);
			$display("TB FAILED");
			$fatal(1, "display update timeout");
		end
	endtask

	// the loop keeps storing the same value while the switches stay put
	task automatic holdDisplay(input logic [7:0] expected);
		for (int i = 0; i < holdCycles; i++)
		begin
			@(negedge Clock_pin);
			checkDisplay(Display_pin, expected);
		end
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial
	begin
		seed = 32'he690b658;
		rstN = 1'b0;
		SW_pin = '0;
		buildTable();

		repeat (16) @(posedge Clock_pin);
		@(negedge Clock_pin);
		rstN = 1'b1;

		// LEDs stay dark until the first display store
		for (int i = 0; i < 8; i++)
		begin
			checkDisplay(Display_pin, 8'h00);
			@(negedge Clock_pin);
		end

		for (int i = 0; i < numEntries; i++)
		begin
			SW_pin = swTable[i];	// still on the falling edge
			$display("entry %0d switches 0x%h expecting 0x%h", i, swTable[i], expTable[i]);
			waitForDisplay(expTable[i]);
			holdDisplay(expTable[i]);
		end

		$display("TB PASSED");
		$finish;
	end

endmodule
